/* verilog/dma_rx_pkg.sv */
/*
 DMA-side types for the receive queue. Packets are limited to
 MAX_PKT_BYTES; the byte count carries one extra bit so 2048 fits.
*/
package dma_rx_pkg;

   localparam int MAX_PKT_BYTES = 2048;
   localparam int BYTE_CNT_W    = $clog2(MAX_PKT_BYTES) + 1;

   typedef logic [BYTE_CNT_W-1:0] byte_cnt_t;
   // Word count is the byte count in 4-byte units
   typedef logic [BYTE_CNT_W-3:0] word_cnt_t;

   // One DMA write, little-endian payload
   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  ctrl;     // One-hot last valid byte, zero mid-packet
      logic        pkt_vld;  // Only meaningful with nonzero ctrl
   } dma_word_t;

   // Length FIFO entry, one per finished packet
   typedef struct packed {
      logic      vld;
      byte_cnt_t byte_len;
   } len_entry_t;

endpackage

/* verilog/udp_pkg.sv */
/*
 Datapath-side types. Words are big endian, ctrl nonzero marks the
 last word of a packet or a module header word.
*/
package udp_pkg;

   localparam int UDP_DATA_W = 32;
   localparam int UDP_CTRL_W = 4;

   typedef struct packed {
      logic [UDP_CTRL_W-1:0] ctrl;
      logic [UDP_DATA_W-1:0] data;
   } udp_word_t;

   // Module header word, top bit first
   typedef struct packed {
      logic [9:0]  word_len;
      logic [5:0]  src_port;
      logic [3:0]  pad;
      logic [11:0] byte_len;
   } udp_hdr_t;

   // Egress FSM states
   typedef enum logic [1:0] {
      WAIT_PKT,
      XFER_PKT,
      DROP_PKT
   } egress_state_t;

endpackage

/* verilog/sync_fifo.sv */
/*
 Single-clock FIFO, first word falls through to rd_data.
 Writes while full and reads while empty are ignored.
*/
`timescale 1ns/1ns

module sync_fifo #(
   parameter int WIDTH             = 36,
   parameter int DEPTH_BITS        = 9,
   parameter int NEARLY_FULL_LEVEL = 500
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             rd_en,
   output logic [WIDTH-1:0] rd_data,
   output logic             full,
   output logic             nearly_full,
   output logic             empty
);

   localparam int DEPTH = 2 ** DEPTH_BITS;

   logic [WIDTH-1:0]    mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  wr_ok;
   logic                  rd_ok;

   assign wr_ok = wr_en && !full;
   assign rd_ok = rd_en && !empty;

   // Head entry is always visible
   assign rd_data     = mem[rd_ptr];
   assign full        = (count == DEPTH);
   assign nearly_full = (count >= NEARLY_FULL_LEVEL);
   assign empty       = (count == 0);

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
         if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
         // Occupancy holds when both happen together
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* verilog/rx_ingress.sv */
/*
 DMA packet framing. The first word of a packet carries the byte
 length and is not stored. Payload words are dropped while the data
 FIFO is full, so the DMA side must respect dma_nearly_full.
*/
`timescale 1ns/1ns

module rx_ingress import dma_rx_pkg::*; import udp_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       dma_wr,
   input  dma_word_t  dma_word,
   input  logic       fifo_full,
   output logic       fifo_wr,
   output udp_word_t  fifo_word,
   output logic       len_wr,
   output len_entry_t len_entry,
   output logic       pkt_stored,
   output logic       pkt_dropped,
   output logic       overrun
);

   logic      in_pkt;
   logic      last_wr;
   byte_cnt_t byte_len;

   ////////////////////////////////////////
   // Byte order swap
   ////////////////////////////////////////

   // Host is little endian, datapath is big endian
   always_comb begin
      for (int k = 0; k < 4; k++) begin
         fifo_word.data[8*k +: 8] = dma_word.data[24-8*k +: 8];
         fifo_word.ctrl[k]        = dma_word.ctrl[3-k];
      end
   end

   assign fifo_wr = dma_wr && in_pkt && !fifo_full;
   assign last_wr = fifo_wr && (dma_word.ctrl != 4'h0);

   ////////////////////////////////////////
   // Framing and length capture
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         in_pkt      <= 1'b0;
         len_wr      <= 1'b0;
         pkt_stored  <= 1'b0;
         pkt_dropped <= 1'b0;
         overrun     <= 1'b0;
      end else begin
         if (dma_wr && !in_pkt) begin
            in_pkt <= 1'b1;
         end else if (dma_wr && dma_word.ctrl != 4'h0) begin
            in_pkt <= 1'b0;
         end
         len_wr      <= last_wr;
         pkt_stored  <= last_wr && dma_word.pkt_vld;
         pkt_dropped <= last_wr && !dma_word.pkt_vld;
         overrun     <= dma_wr && fifo_full;
      end
   end

   // Length word arrives first, the entry goes out with the last word
   always_ff @(posedge clk) begin
      if (dma_wr && !in_pkt) begin
         byte_len <= dma_word.data[BYTE_CNT_W-1:0];
      end
      if (last_wr) begin
         len_entry.vld      <= dma_word.pkt_vld;
         len_entry.byte_len <= byte_len;
      end
   end

endmodule

/* verilog/rx_egress.sv */
/*
 Egress FSM. Starts only when a whole packet is queued, which the
 length FIFO entry guarantees. Outputs are registered, so out_wr
 follows a cycle with out_rdy high.
*/
`timescale 1ns/1ns

module rx_egress import dma_rx_pkg::*; import udp_pkg::*; #(
   parameter bit         ENABLE_HEADER = 1'b0,
   parameter logic [3:0] STAGE_NUMBER  = 4'hf,
   parameter logic [5:0] PORT_NUMBER   = 6'd0
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       len_empty,
   input  len_entry_t len_entry,
   output logic       len_rd,
   input  udp_word_t  fifo_word,
   output logic       fifo_rd,
   input  logic       out_rdy,
   output logic       out_wr,
   output udp_word_t  out_word,
   output logic       pkt_removed
);

   egress_state_t state;
   egress_state_t state_nxt;
   logic          out_wr_nxt;
   udp_word_t     out_word_nxt;
   word_cnt_t     word_len;
   udp_hdr_t      hdr;
   logic          last_word;

   // Round the byte length up to whole words
   assign word_len = len_entry.byte_len[BYTE_CNT_W-1:2]
                   + word_cnt_t'(|len_entry.byte_len[1:0]);

   always_comb begin
      hdr.word_len = word_len;
      hdr.src_port = PORT_NUMBER;
      hdr.pad      = 4'h0;
      hdr.byte_len = len_entry.byte_len;
   end

   assign last_word = (fifo_word.ctrl != 4'h0);

   always_comb begin
      state_nxt    = state;
      out_wr_nxt   = 1'b0;
      out_word_nxt = '0;
      fifo_rd      = 1'b0;
      len_rd       = 1'b0;
      pkt_removed  = 1'b0;
      case (state)
         WAIT_PKT: begin
            if (!len_empty && !len_entry.vld) begin
               state_nxt = DROP_PKT;
            end else if (!len_empty && out_rdy) begin
               out_wr_nxt = 1'b1;
               if (ENABLE_HEADER) begin
                  out_word_nxt.ctrl = STAGE_NUMBER;
                  out_word_nxt.data = hdr;
                  state_nxt         = XFER_PKT;
               end else begin
                  out_word_nxt = fifo_word;
                  fifo_rd      = 1'b1;
                  len_rd       = last_word;
                  pkt_removed  = last_word;
                  state_nxt    = last_word ? WAIT_PKT : XFER_PKT;
               end
            end
         end
         XFER_PKT: begin
            if (out_rdy) begin
               out_wr_nxt   = 1'b1;
               out_word_nxt = fifo_word;
               fifo_rd      = 1'b1;
               if (last_word) begin
                  len_rd      = 1'b1;
                  pkt_removed = 1'b1;
                  state_nxt   = WAIT_PKT;
               end
            end
         end
         // Invalid packet, drain one word per cycle with no output
         DROP_PKT: begin
            fifo_rd = 1'b1;
            if (last_word) begin
               len_rd    = 1'b1;
               state_nxt = WAIT_PKT;
            end
         end
         default: state_nxt = WAIT_PKT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= WAIT_PKT;
         out_wr <= 1'b0;
      end else begin
         state  <= state_nxt;
         out_wr <= out_wr_nxt;
      end
   end

   always_ff @(posedge clk) begin
      out_word <= out_word_nxt;
   end

endmodule

/* verilog/rx_queue_stats.sv */
/*
 Event counters, each saturating at all ones. pkts_in_q counts only
 valid packets and relies on the length FIFO depth to stay in range.
*/
`timescale 1ns/1ns

module rx_queue_stats (
   input  logic        clk,
   input  logic        reset,
   input  logic        pkt_stored,
   input  logic        pkt_dropped,
   input  logic        pkt_removed,
   input  logic        overrun,
   output logic [15:0] stored_cnt,
   output logic [15:0] dropped_cnt,
   output logic [15:0] removed_cnt,
   output logic [15:0] overrun_cnt,
   output logic [3:0]  pkts_in_q
);

   logic [3:0]  evt;
   logic [15:0] cnt [4];

   assign evt = {overrun, pkt_removed, pkt_dropped, pkt_stored};

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            cnt[i] <= '0;
         end
         pkts_in_q <= '0;
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (evt[i] && cnt[i] != 16'hffff) begin
               cnt[i] <= cnt[i] + 1'b1;
            end
         end
         // Stored and removed together leave the level unchanged
         case ({pkt_removed, pkt_stored})
            2'b01:   pkts_in_q <= pkts_in_q + 1'b1;
            2'b10:   pkts_in_q <= pkts_in_q - 1'b1;
            default: pkts_in_q <= pkts_in_q;
         endcase
      end
   end

   assign stored_cnt  = cnt[0];
   assign dropped_cnt = cnt[1];
   assign removed_cnt = cnt[2];
   assign overrun_cnt = cnt[3];

endmodule

/* verilog/cpu_dma_rx_queue.sv */
/*
 Host-to-datapath receive queue, 32-bit datapath only.
 dma_nearly_full lags the FIFO flags by one cycle; the DMA side may
 finish a packet but must not start one while it is high.
*/
`timescale 1ns/1ns

module cpu_dma_rx_queue import dma_rx_pkg::*; import udp_pkg::*; #(
   parameter bit         ENABLE_HEADER   = 1'b0,
   parameter logic [3:0] STAGE_NUMBER    = 4'hf,
   parameter logic [5:0] PORT_NUMBER     = 6'd0,
   parameter int         DATA_DEPTH_BITS = 9,
   parameter int         DATA_NF_LEVEL   = 500,
   parameter int         LEN_DEPTH_BITS  = 3,
   parameter int         LEN_NF_LEVEL    = 7
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        dma_wr,
   input  dma_word_t   dma_word,
   output logic        dma_nearly_full,
   output logic        out_wr,
   output udp_word_t   out_word,
   input  logic        out_rdy,
   output logic [15:0] stored_cnt,
   output logic [15:0] dropped_cnt,
   output logic [15:0] removed_cnt,
   output logic [15:0] overrun_cnt,
   output logic [3:0]  pkts_in_q
);

   logic       fifo_wr;
   logic       fifo_rd;
   logic       fifo_full;
   logic       fifo_nf;
   udp_word_t  fifo_in;
   udp_word_t  fifo_out;
   logic       len_wr;
   logic       len_rd;
   logic       len_nf;
   logic       len_empty;
   len_entry_t len_in;
   len_entry_t len_out;
   logic       pkt_stored;
   logic       pkt_dropped;
   logic       pkt_removed;
   logic       overrun;

   rx_ingress i_ingress (
      .clk, .reset, .dma_wr, .dma_word,
      .fifo_full, .fifo_wr, .fifo_word(fifo_in),
      .len_wr, .len_entry(len_in),
      .pkt_stored, .pkt_dropped, .overrun
   );

   // Payload words with ctrl on top
   sync_fifo #(
      .WIDTH($bits(udp_word_t)), .DEPTH_BITS(DATA_DEPTH_BITS),
      .NEARLY_FULL_LEVEL(DATA_NF_LEVEL)
   ) i_data_fifo (
      .clk, .reset, .wr_en(fifo_wr), .wr_data(fifo_in),
      .rd_en(fifo_rd), .rd_data(fifo_out),
      .full(fifo_full), .nearly_full(fifo_nf), .empty()
   );

   // One entry per finished packet
   // nearly_full holds off the DMA before this FIFO fills
   sync_fifo #(
      .WIDTH($bits(len_entry_t)), .DEPTH_BITS(LEN_DEPTH_BITS),
      .NEARLY_FULL_LEVEL(LEN_NF_LEVEL)
   ) i_len_fifo (
      .clk, .reset, .wr_en(len_wr), .wr_data(len_in),
      .rd_en(len_rd), .rd_data(len_out),
      .full(), .nearly_full(len_nf), .empty(len_empty)
   );

   rx_egress #(
      .ENABLE_HEADER(ENABLE_HEADER), .STAGE_NUMBER(STAGE_NUMBER),
      .PORT_NUMBER(PORT_NUMBER)
   ) i_egress (
      .clk, .reset, .len_empty, .len_entry(len_out), .len_rd,
      .fifo_word(fifo_out), .fifo_rd,
      .out_rdy, .out_wr, .out_word, .pkt_removed
   );

   rx_queue_stats i_stats (
      .clk, .reset, .pkt_stored, .pkt_dropped, .pkt_removed, .overrun,
      .stored_cnt, .dropped_cnt, .removed_cnt, .overrun_cnt, .pkts_in_q
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         dma_nearly_full <= 1'b0;
      end else begin
         dma_nearly_full <= fifo_nf || len_nf;
      end
   end

endmodule

/* bench/tb_cpu_dma_rx_queue.sv */
/*
 Directed testbench for the receive queue with the module header on.
 Packets stay short, so the data FIFO never reaches its nearly-full level.
*/
`timescale 1ns/1ns

module tb_cpu_dma_rx_queue
   import dma_rx_pkg::*;
   import udp_pkg::*;
();

   localparam logic [5:0] PORT       = 6'd5;
   localparam logic [3:0] STAGE      = 4'hf;
   // About 100 output words in total, plus slack for out_rdy gaps
   localparam int         MAX_CYCLES = 4000;

   typedef logic [7:0] byte_q_t [$];

   logic        clk;
   logic        reset;
   logic        dma_wr;
   dma_word_t   dma_word;
   logic        dma_nearly_full;
   logic        out_wr;
   udp_word_t   out_word;
   logic        out_rdy;
   logic [15:0] stored_cnt;
   logic [15:0] dropped_cnt;
   logic [15:0] removed_cnt;
   logic [15:0] overrun_cnt;
   logic [3:0]  pkts_in_q;

   udp_word_t   exp_q [$];
   logic [31:0] lfsr_state;
   int          mismatch_cnt;
   int          error_cnt;
   int          cycle_cnt = 0;
   logic        rdy_prev;
   logic        sent_all;

   cpu_dma_rx_queue #(
      .ENABLE_HEADER(1'b1), .STAGE_NUMBER(STAGE), .PORT_NUMBER(PORT)
   ) i_dut (
      .clk, .reset, .dma_wr, .dma_word, .dma_nearly_full,
      .out_wr, .out_word, .out_rdy,
      .stored_cnt, .dropped_cnt, .removed_cnt, .overrun_cnt, .pkts_in_q
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Random source
   ////////////////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic rand_bit();
      lfsr_state = lfsr_step(lfsr_state);
      return lfsr_state[0];
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [7:0] b = '0;
      for (int i = 0; i < 8; i++) begin
         b = {b[6:0], rand_bit()};
      end
      return b;
   endfunction

   function automatic byte_q_t random_bytes(input int len);
      byte_q_t q;
      for (int i = 0; i < len; i++) begin
         q.push_back(rand_byte());
      end
      return q;
   endfunction

   ////////////////////////////////////////
   // Packet helpers
   ////////////////////////////////////////

   // Bytes past the packet end read as zero
   function automatic logic [7:0] byte_at(input byte_q_t q, input int idx);
      return (idx < q.size()) ? q[idx] : 8'h00;
   endfunction

   function automatic int last_bytes(input int len);
      return (len % 4 == 0) ? 4 : len % 4;
   endfunction

   // word_len, src_port, pad, byte_len from the top bit down
   function automatic udp_word_t header_word(input int len);
      udp_word_t w;
      w.ctrl = STAGE;
      w.data = {10'((len + 3) / 4), PORT, 4'h0, 12'(len)};
      return w;
   endfunction

   task automatic expect_packet(input byte_q_t q);
      int        nwords;
      udp_word_t w;
      nwords = (q.size() + 3) / 4;
      exp_q.push_back(header_word(q.size()));
      for (int i = 0; i < nwords; i++) begin
         // First byte of the packet ends up in the top byte lane
         w.data = {byte_at(q, 4*i), byte_at(q, 4*i + 1),
                   byte_at(q, 4*i + 2), byte_at(q, 4*i + 3)};
         w.ctrl = (i == nwords - 1) ? 4'b1000 >> (last_bytes(q.size()) - 1) : 4'h0;
         exp_q.push_back(w);
      end
   endtask

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   // Length word first, then little-endian payload
   task automatic send_packet(input byte_q_t q, input logic vld);
      int nwords;
      nwords = (q.size() + 3) / 4;
      if (vld) begin
         expect_packet(q);
      end
      while (dma_nearly_full) begin
         step();
      end
      dma_wr           = 1'b1;
      dma_word.data    = 32'(q.size());
      dma_word.ctrl    = 4'h0;
      dma_word.pkt_vld = 1'b0;
      step();
      for (int i = 0; i < nwords; i++) begin
         dma_word.data    = {byte_at(q, 4*i + 3), byte_at(q, 4*i + 2),
                             byte_at(q, 4*i + 1), byte_at(q, 4*i)};
         dma_word.ctrl    = (i == nwords - 1) ? 4'b0001 << (last_bytes(q.size()) - 1) : 4'h0;
         dma_word.pkt_vld = (i == nwords - 1) && vld;
         step();
      end
      dma_wr   = 1'b0;
      dma_word = '0;
   endtask

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   task automatic report_error(input string msg);
      $display("ERROR: %s", msg);
      error_cnt++;
   endtask

   task automatic check_word(input string name, input udp_word_t got, input udp_word_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got %h expected %h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_count(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got %h expected %h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got %h expected %h", name, got, exp);
         mismatch_cnt++;
      end
   endtask

   // Mid-cycle sampling, after registered outputs have settled
   always @(negedge clk) begin : out_monitor
      udp_word_t exp_w;
      if (!reset && out_wr) begin
         if (!rdy_prev) begin
            report_error("out_wr went high without out_rdy in the cycle before");
         end
         if (exp_q.size() == 0) begin
            report_error($sformatf("unexpected output word %h", out_word));
         end else begin
            exp_w = exp_q.pop_front();
            check_word("out_word", out_word, exp_w);
         end
      end
      rdy_prev = out_rdy;
   end

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < limit) begin
         step();
         n++;
      end
      if (exp_q.size() != 0) begin
         report_error($sformatf("%0d expected words never came out", exp_q.size()));
      end
   endtask

   task automatic reset_dut();
      reset    = 1'b1;
      dma_wr   = 1'b0;
      dma_word = '0;
      out_rdy  = 1'b0;
      repeat (2) step();
      reset = 1'b0;
      check_flag("out_wr", out_wr, 1'b0);
      check_flag("dma_nearly_full", dma_nearly_full, 1'b0);
      check_count("stored_cnt", stored_cnt, 16'h0);
      check_count("dropped_cnt", dropped_cnt, 16'h0);
      check_count("removed_cnt", removed_cnt, 16'h0);
      check_count("overrun_cnt", overrun_cnt, 16'h0);
      check_count("pkts_in_q", 16'(pkts_in_q), 16'h0);
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   task automatic test_single_packet();
      reset_dut();
      out_rdy = 1'b1;
      send_packet(random_bytes(13), 1'b1);
      wait_drain(100);
      check_count("stored_cnt", stored_cnt, 16'd1);
      check_count("removed_cnt", removed_cnt, 16'd1);
   endtask

   task automatic test_last_word_lengths();
      int lens [5] = '{4, 5, 6, 7, 64};
      reset_dut();
      out_rdy = 1'b1;
      foreach (lens[i]) begin
         send_packet(random_bytes(lens[i]), 1'b1);
      end
      wait_drain(300);
      check_count("stored_cnt", stored_cnt, 16'd5);
      check_count("removed_cnt", removed_cnt, 16'd5);
   endtask

   task automatic test_invalid_drop();
      reset_dut();
      out_rdy = 1'b1;
      send_packet(random_bytes(10), 1'b1);
      send_packet(random_bytes(9), 1'b0);
      send_packet(random_bytes(11), 1'b1);
      wait_drain(200);
      check_count("dropped_cnt", dropped_cnt, 16'd1);
      check_count("stored_cnt", stored_cnt, 16'd2);
      check_count("removed_cnt", removed_cnt, 16'd2);
      check_count("pkts_in_q", 16'(pkts_in_q), 16'd0);
   endtask

   task automatic test_back_pressure();
      byte_q_t p0;
      byte_q_t p1;
      byte_q_t p2;
      reset_dut();
      p0       = random_bytes(17);
      p1       = random_bytes(8);
      p2       = random_bytes(23);
      sent_all = 1'b0;
      fork
         begin
            send_packet(p0, 1'b1);
            send_packet(p1, 1'b1);
            send_packet(p2, 1'b1);
            sent_all = 1'b1;
         end
         begin
            while (!sent_all || exp_q.size() != 0) begin
               out_rdy = rand_bit();
               step();
            end
         end
      join
      out_rdy = 1'b1;
      check_count("stored_cnt", stored_cnt, 16'd3);
      check_count("removed_cnt", removed_cnt, 16'd3);
      check_count("pkts_in_q", 16'(pkts_in_q), 16'd0);
   endtask

   // Seven entries reach the length FIFO's nearly-full level
   task automatic test_queue_fill();
      int n;
      reset_dut();
      for (int i = 0; i < 7; i++) begin
         send_packet(random_bytes(5 + i), 1'b1);
      end
      n = 0;
      while (!dma_nearly_full && n < 10) begin
         step();
         n++;
      end
      check_flag("dma_nearly_full", dma_nearly_full, 1'b1);
      check_count("pkts_in_q", 16'(pkts_in_q), 16'd7);
      check_count("overrun_cnt", overrun_cnt, 16'd0);
      out_rdy = 1'b1;
      wait_drain(400);
      check_count("removed_cnt", removed_cnt, 16'd7);
      check_count("pkts_in_q", 16'(pkts_in_q), 16'd0);
      check_count("overrun_cnt", overrun_cnt, 16'd0);
   endtask

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      dma_wr       = 1'b0;
      dma_word     = '0;
      out_rdy      = 1'b0;
      rdy_prev     = 1'b0;
      sent_all     = 1'b0;
      lfsr_state   = 32'h727c3c9a;
      mismatch_cnt = 0;
      error_cnt    = 0;
      test_single_packet();
      test_last_word_lengths();
      test_invalid_drop();
      test_back_pressure();
      test_queue_fill();
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, error_cnt);
      if (mismatch_cnt == 0 && error_cnt == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* files.f */
verilog/dma_rx_pkg.sv
verilog/udp_pkg.sv
verilog/sync_fifo.sv
verilog/rx_ingress.sv
verilog/rx_egress.sv
verilog/rx_queue_stats.sv
verilog/cpu_dma_rx_queue.sv
bench/tb_cpu_dma_rx_queue.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the receive queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f files.f \
   --top-module tb_cpu_dma_rx_queue -Mdir obj_dir > build.log 2>&1 &&
   ./obj_dir/Vtb_cpu_dma_rx_queue > sim.log 2>&1
cat build.log sim.log 2> /dev/null
grep -q "^Simulation completed successfully$" sim.log && echo "PASS" ||
   { echo "FAIL"; exit 1; }
